// File: core_top.f
+incdir+include
source/rv_isa_pkg.sv
source/core_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/execute.sv
source/mem_writeback.sv
source/core_top.sv
tests/tb_core_top.sv

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import rv_isa_pkg::*, core_pkg::*;
(
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire alu_op_t op,
    output word_t        result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts only look at five bits

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_t;

    // first alu operand
    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO
    } src_a_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_SNPC  // link address for jal/jalr
    } wb_sel_t;

endpackage

`default_nettype wire

// File: source/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top
    import rv_isa_pkg::*, core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire word_t imem_rdata,
    input  wire word_t dmem_rdata,
    output word_t      imem_addr,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic       dmem_we,
    output logic [3:0] dmem_wstrb
);
    word_t      pc, snpc, imm;
    word_t      rs1_data, rs2_data, alu_result, jump_target, rd_wdata;
    reg_addr_t  rs1, rs2, rd;
    src_a_sel_t src_a_sel;
    alu_op_t    alu_op;
    branch_fn_t branch_fn;
    mem_size_t  mem_size;
    wb_sel_t    wb_sel;
    logic       src_b_imm, is_branch, is_jump, is_load, is_store, rd_we, take_jump;

    assign imem_addr = pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk), .reset(reset),
        .take_jump(take_jump), .jump_target(jump_target),
        .pc(pc), .snpc(snpc)
    );

    decoder u_decoder (
        .clk(clk), .reset(reset), .inst(imem_rdata),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .src_a_sel(src_a_sel), .src_b_imm(src_b_imm), .alu_op(alu_op),
        .is_branch(is_branch), .branch_fn(branch_fn), .is_jump(is_jump),
        .is_load(is_load), .is_store(is_store), .mem_size(mem_size),
        .wb_sel(wb_sel), .rd_we(rd_we)
    );

    reg_file u_reg_file (
        .clk(clk),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .rd_we(rd_we), .rd_wdata(rd_wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute u_execute (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .src_a_sel(src_a_sel), .src_b_imm(src_b_imm), .alu_op(alu_op),
        .is_branch(is_branch), .is_jump(is_jump), .branch_fn(branch_fn),
        .alu_result(alu_result), .take_jump(take_jump), .jump_target(jump_target)
    );

    mem_writeback u_mem_wb (
        .clk(clk), .reset(reset),
        .is_load(is_load), .is_store(is_store), .mem_size(mem_size),
        .alu_result(alu_result), .rs2_data(rs2_data), .snpc(snpc),
        .wb_sel(wb_sel), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_wstrb(dmem_wstrb),
        .rd_wdata(rd_wdata)
    );

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder
    import rv_isa_pkg::*, core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire word_t inst,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output reg_addr_t  rd,
    output word_t      imm,
    output src_a_sel_t src_a_sel,
    output logic       src_b_imm,
    output alu_op_t    alu_op,
    output logic       is_branch,
    output branch_fn_t branch_fn,
    output logic       is_jump,
    output logic       is_load,
    output logic       is_store,
    output mem_size_t  mem_size,
    output wb_sel_t    wb_sel,
    output logic       rd_we
);
    opcode_t    opcode;
    logic [2:0] funct3;
    inst_fmt_t  fmt;

    // alt selects sub or sra, caller decides when funct7 bit 5 counts
    function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode    = opcode_t'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign rd        = inst[11:7];
    assign branch_fn = branch_fn_t'(funct3);
    assign mem_size  = mem_size_t'(funct3);

    always_comb begin
        case (opcode)
            OP_REG:                   fmt = FMT_R;
            OP_IMM, OP_LOAD, OP_JALR: fmt = FMT_I;
            OP_STORE:                 fmt = FMT_S;
            OP_BRANCH:                fmt = FMT_B;
            OP_LUI, OP_AUIPC:         fmt = FMT_U;
            OP_JAL:                   fmt = FMT_J;
            default:                  fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'b0};
            FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;  // r type has none
        endcase
    end

    always_comb begin
        src_a_sel = SRC_A_RS1;
        src_b_imm = 1'b0;
        alu_op    = ALU_ADD;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        wb_sel    = WB_ALU;
        rd_we     = 1'b0;
        case (opcode)
            OP_REG: begin
                rd_we  = 1'b1;
                alu_op = alu_fn(funct3, inst[30]);
            end
            OP_IMM: begin
                rd_we     = 1'b1;
                src_b_imm = 1'b1;
                alu_op    = alu_fn(funct3, (funct3 == 3'b101) & inst[30]);  // no subi
            end
            OP_LOAD: begin
                rd_we     = 1'b1;
                src_b_imm = 1'b1;
                is_load   = 1'b1;
                wb_sel    = WB_LOAD;
            end
            OP_STORE: begin
                src_b_imm = 1'b1;
                is_store  = 1'b1;
            end
            OP_BRANCH: is_branch = 1'b1;  // target comes from its own adder
            OP_JAL: begin
                rd_we     = 1'b1;
                is_jump   = 1'b1;
                src_a_sel = SRC_A_PC;
                src_b_imm = 1'b1;
                wb_sel    = WB_SNPC;
            end
            OP_JALR: begin
                rd_we     = 1'b1;
                is_jump   = 1'b1;
                src_b_imm = 1'b1;
                wb_sel    = WB_SNPC;
            end
            OP_LUI: begin
                rd_we     = 1'b1;
                src_a_sel = SRC_A_ZERO;
                src_b_imm = 1'b1;
                alu_op    = ALU_PASS_B;
            end
            OP_AUIPC: begin
                rd_we     = 1'b1;
                src_a_sel = SRC_A_PC;
                src_b_imm = 1'b1;
            end
            default: ;  // unsupported opcode retires as a no-op
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) fmt != FMT_NONE)
        else $error("unsupported opcode %b", inst[6:0]);

endmodule

`default_nettype wire

// File: source/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
    import rv_isa_pkg::*, core_pkg::*;
(
    input  wire word_t      pc,
    input  wire word_t      rs1_data,
    input  wire word_t      rs2_data,
    input  wire word_t      imm,
    input  wire src_a_sel_t src_a_sel,
    input  wire logic       src_b_imm,
    input  wire alu_op_t    alu_op,
    input  wire logic       is_branch,
    input  wire logic       is_jump,
    input  wire branch_fn_t branch_fn,
    output word_t           alu_result,
    output logic            take_jump,
    output word_t           jump_target
);
    word_t op_a;
    word_t op_b;
    word_t branch_target;
    logic  branch_cond;

    always_comb begin
        case (src_a_sel)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b = src_b_imm ? imm : rs2_data;

    alu u_alu (
        .a(op_a), .b(op_b), .op(alu_op), .result(alu_result)
    );

    always_comb begin
        case (branch_fn)
            BR_EQ:   branch_cond = rs1_data == rs2_data;
            BR_NE:   branch_cond = rs1_data != rs2_data;
            BR_LT:   branch_cond = $signed(rs1_data) < $signed(rs2_data);
            BR_GE:   branch_cond = $signed(rs1_data) >= $signed(rs2_data);
            BR_LTU:  branch_cond = rs1_data < rs2_data;
            BR_GEU:  branch_cond = rs1_data >= rs2_data;
            default: branch_cond = 1'b0;
        endcase
    end

    assign branch_target = pc + imm;

    // jalr needs bit 0 cleared, a jal sum is even already
    assign jump_target = is_jump ? {alu_result[31:1], 1'b0} : branch_target;
    assign take_jump   = is_jump | (is_branch & branch_cond);

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
    import rv_isa_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  take_jump,
    input  wire word_t jump_target,
    output word_t      pc,
    output word_t      snpc
);
    word_t next_pc;

    assign snpc    = pc + 32'd4;
    assign next_pc = take_jump ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // jump targets from execute must keep the pc word aligned
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

// File: source/mem_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module mem_writeback
    import rv_isa_pkg::*, core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      is_load,
    input  wire logic      is_store,
    input  wire mem_size_t mem_size,
    input  wire word_t     alu_result,
    input  wire word_t     rs2_data,
    input  wire word_t     snpc,
    input  wire wb_sel_t   wb_sel,
    input  wire word_t     dmem_rdata,
    output word_t          dmem_addr,
    output word_t          dmem_wdata,
    output logic           dmem_we,
    output logic [3:0]     dmem_wstrb,
    output word_t          rd_wdata
);
    logic [1:0] offset;
    logic [3:0] size_strb;
    logic       misaligned;
    word_t      store_data;
    word_t      lane_data;
    word_t      load_data;

    assign offset    = alu_result[1:0];
    assign dmem_addr = {alu_result[31:2], 2'b00};
    assign dmem_we   = is_store & ~reset;

    always_comb begin
        case (mem_size)
            MEM_B, MEM_BU: begin
                store_data = {24'b0, rs2_data[7:0]};
                size_strb  = 4'b0001;
            end
            MEM_H, MEM_HU: begin
                store_data = {16'b0, rs2_data[15:0]};
                size_strb  = 4'b0011;
            end
            default: begin
                store_data = rs2_data;
                size_strb  = 4'b1111;
            end
        endcase
    end

    assign dmem_wdata = store_data << {offset, 3'b000};          // move into byte lanes
    assign dmem_wstrb = is_store ? size_strb << offset : 4'b0000;

    assign lane_data = dmem_rdata >> {offset, 3'b000};  // addressed byte down to lane 0

    always_comb begin
        case (mem_size)
            MEM_B:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            MEM_BU:  load_data = {24'b0, lane_data[7:0]};
            MEM_H:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            MEM_HU:  load_data = {16'b0, lane_data[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD: rd_wdata = load_data;
            WB_SNPC: rd_wdata = snpc;
            default: rd_wdata = alu_result;
        endcase
    end

    assign misaligned = ((mem_size == MEM_H || mem_size == MEM_HU) && offset[0])
                      || (mem_size == MEM_W && offset != 2'b00);

    assert property (@(posedge clk) disable iff (reset) (is_load || is_store) |-> !misaligned)
        else $error("misaligned access at %h", alu_result);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
(
    input  wire logic      clk,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    input  wire reg_addr_t rd,
    input  wire logic      rd_we,
    input  wire word_t     rd_wdata,
    output word_t          rs1_data,
    output word_t          rs2_data
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rd_we && rd != 5'd0) begin  // x0 stays zero
            regs[rd] <= rd_wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
    } inst_fmt_t;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_fn_t;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_t;

    localparam word_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int REF_DMEM_WORDS = 1024;  // model data memory, indexed by addr[11:2]

function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(input word_t imm, input reg_addr_t rs1, input logic [2:0] f3,
                                input reg_addr_t rd, input opcode_t op);
    return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(input word_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_u(input word_t imm, input reg_addr_t rd, input opcode_t op);
    return {imm[31:12], rd, op};
endfunction

function automatic word_t enc_j(input word_t imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// numerical recipes constants, seeded with 77 by the testbench
function automatic word_t lcg_next(ref word_t state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

function automatic word_t ref_alu(input logic [2:0] f3, input word_t a, input word_t b,
                                  input logic alt);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// one architectural step, reports the store it made
function automatic void ref_step(input word_t inst, ref word_t pc, ref word_t regs [32],
                                 ref word_t dmem [REF_DMEM_WORDS], output logic st_en,
                                 output word_t st_addr, output word_t st_data,
                                 output logic [3:0] st_strb);
    word_t      a, b, imm_i, ea, ld, rd_val, npc;
    logic [2:0] f3;
    logic       wr, taken;
    a       = regs[inst[19:15]];
    b       = regs[inst[24:20]];
    f3      = inst[14:12];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    npc     = pc + 32'd4;
    wr      = 1'b1;
    rd_val  = '0;
    st_en   = 1'b0;
    st_addr = '0;
    st_data = '0;
    st_strb = '0;
    case (inst[6:0])
        OP_REG, OP_IMM: rd_val = ref_alu(f3, a, inst[5] ? b : imm_i,
                                         inst[30] & (inst[5] | f3 == 3'b101));
        OP_LUI:   rd_val = {inst[31:12], 12'b0};
        OP_AUIPC: rd_val = pc + {inst[31:12], 12'b0};
        OP_JAL: begin
            rd_val = npc;
            npc    = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OP_JALR: begin
            rd_val = npc;
            npc    = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            wr = 1'b0;
            case (f3)
                BR_EQ:   taken = a == b;
                BR_NE:   taken = a != b;
                BR_LT:   taken = $signed(a) < $signed(b);
                BR_GE:   taken = $signed(a) >= $signed(b);
                BR_LTU:  taken = a < b;
                default: taken = a >= b;
            endcase
            if (taken) begin
                npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        OP_LOAD: begin
            ea = a + imm_i;
            ld = dmem[ea[11:2]] >> {ea[1:0], 3'b000};
            case (f3)
                MEM_B:   rd_val = {{24{ld[7]}}, ld[7:0]};
                MEM_H:   rd_val = {{16{ld[15]}}, ld[15:0]};
                MEM_BU:  rd_val = {24'b0, ld[7:0]};
                MEM_HU:  rd_val = {16'b0, ld[15:0]};
                default: rd_val = ld;
            endcase
        end
        OP_STORE: begin
            wr      = 1'b0;
            ea      = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            st_en   = 1'b1;
            st_addr = {ea[31:2], 2'b00};
            st_strb = (f3 == MEM_B) ? 4'b0001 : (f3 == MEM_H) ? 4'b0011 : 4'b1111;
            st_strb = st_strb << ea[1:0];
            st_data = (f3 == MEM_B) ? {24'b0, b[7:0]} : (f3 == MEM_H) ? {16'b0, b[15:0]} : b;
            st_data = st_data << {ea[1:0], 3'b000};
            for (int i = 0; i < 4; i++) begin
                if (st_strb[i]) begin
                    dmem[ea[11:2]][8*i +: 8] = st_data[8*i +: 8];
                end
            end
        end
        default: wr = 1'b0;  // unsupported opcode is a no-op
    endcase
    if (wr && inst[11:7] != 5'd0) begin
        regs[inst[11:7]] = rd_val;
    end
    pc = npc;
endfunction

`endif

// File: tests/tb_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core_top
    import rv_isa_pkg::*;
;
    `include "tb_ref_model.svh"

    localparam word_t RESET_PC  = 32'h0000_0200;
    localparam word_t DUMP_BASE = 32'h0000_0400;  // register dump area with one word per slot
    localparam word_t MEM_BASE  = 32'h0000_0600;  // load/store lane tests

    logic       clk;
    logic       reset;
    word_t      imem_rdata;
    word_t      dmem_rdata;
    word_t      imem_addr;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic       dmem_we;
    logic [3:0] dmem_wstrb;

    word_t imem [REF_DMEM_WORDS];
    word_t dmem [REF_DMEM_WORDS];
    word_t prog [$];
    word_t seed;
    word_t end_pc;
    logic  prog_ready;
    int    dump_slot;

    // architectural model state
    word_t      m_pc;
    word_t      m_regs [32];
    word_t      m_dmem [REF_DMEM_WORDS];
    logic       st_en;
    word_t      st_addr;
    word_t      st_data;
    logic [3:0] st_strb;

    int checks;
    int mismatches;
    int other_errors;

    core_top #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk(clk), .reset(reset),
        .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_wstrb(dmem_wstrb)
    );

    always #50 clk = ~clk;

    assign imem_rdata = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_wstrb[i]) begin
                    dmem[dmem_addr[11:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_store(input logic we, input word_t addr, input word_t data,
                               input logic [3:0] strb, input logic exp_en,
                               input word_t exp_addr, input word_t exp_data,
                               input logic [3:0] exp_strb);
        checks++;
        if (we !== exp_en) begin
            mismatches++;
            $display("Mismatch dmem_we: got %h, expected %h", we, exp_en);
        end else if (exp_en) begin
            check_word("dmem_addr", addr, exp_addr);
            check_word("dmem_wdata", data, exp_data);
            if (strb !== exp_strb) begin
                mismatches++;
                $display("Mismatch dmem_wstrb: got %h, expected %h", strb, exp_strb);
            end
        end
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    // lui then addi with the upper part rounded for the signed low twelve bits
    task automatic load_const(input reg_addr_t rd, input word_t v);
        emit(enc_u(v + 32'h800, rd, OP_LUI));
        emit(enc_i(v, rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic dump_reg(input reg_addr_t r);
        emit(enc_s(DUMP_BASE + word_t'(4 * dump_slot), r, 5'd0, MEM_W));
        dump_slot++;
    endtask

    task automatic build_program();
        word_t      r;
        word_t      r2;
        word_t      imm;
        logic [2:0] f3;
        logic       alt;
        logic [2:0] br_codes [6];
        reg_addr_t  pair_a [5];
        reg_addr_t  pair_b [5];
        br_codes = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        pair_a   = '{5'd1, 5'd3, 5'd4, 5'd5, 5'd6};
        pair_b   = '{5'd2, 5'd4, 5'd3, 5'd6, 5'd5};
        dump_reg(5'd0);  // store held at the reset pc while reset is high
        for (int i = 1; i < 32; i++) begin
            load_const(reg_addr_t'(i), lcg_next(seed));
        end
        for (int i = 0; i < 40; i++) begin
            r   = lcg_next(seed);
            r2  = lcg_next(seed);
            f3  = r[16:14];
            alt = r[13] && (f3 == 3'b000 || f3 == 3'b101);
            if (r[12:11] <= 2'd1) begin
                emit(enc_r(alt ? 7'h20 : 7'h00, r[21:17], r[26:22], f3, r[31:27]));
            end else if (r[12:11] == 2'd2) begin
                imm = r2;
                if (f3 == 3'b001 || f3 == 3'b101) begin  // shift immediates
                    imm = {20'b0, (alt && f3 == 3'b101) ? 7'h20 : 7'h00, r2[4:0]};
                end
                emit(enc_i(imm, r[26:22], f3, r[31:27], OP_IMM));
            end else begin
                emit(enc_u(r2, r[31:27], r[10] ? OP_LUI : OP_AUIPC));
            end
        end
        emit(enc_i(32'h7FF, 5'd31, 3'b110, 5'd0, OP_IMM));  // ori into x0 is dropped
        for (int i = 0; i < 32; i++) begin
            dump_reg(reg_addr_t'(i));  // x0 included
        end
        // branch operands that are equal, signed negative or unsigned large
        load_const(5'd1, 32'h1234_5678);
        load_const(5'd2, 32'h1234_5678);
        load_const(5'd3, 32'hFFFF_FFFB);
        load_const(5'd4, 32'h0000_0003);
        load_const(5'd5, 32'h8000_0000);
        load_const(5'd6, 32'h0000_0001);
        load_const(5'd7, 32'h0);
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 5; j++) begin
                emit(enc_b(32'd8, pair_b[j], pair_a[j], br_codes[i]));
                emit(enc_i(32'd1, 5'd7, 3'b000, 5'd7, OP_IMM));  // skipped if taken
            end
        end
        dump_reg(5'd7);
        load_const(5'd9, 32'h0);
        emit(enc_j(32'd12, 5'd8));
        emit(enc_i(32'd1, 5'd9, 3'b000, 5'd9, OP_IMM));
        emit(enc_i(32'd1, 5'd9, 3'b000, 5'd9, OP_IMM));
        emit(enc_u(32'h0, 5'd10, OP_AUIPC));
        emit(enc_i(32'd16, 5'd10, 3'b000, 5'd11, OP_JALR));
        emit(enc_i(32'd1, 5'd9, 3'b000, 5'd9, OP_IMM));
        emit(enc_i(32'd1, 5'd9, 3'b000, 5'd9, OP_IMM));
        emit(enc_u(32'h0, 5'd10, OP_AUIPC));
        emit(enc_i(32'd13, 5'd10, 3'b000, 5'd12, OP_JALR));  // odd target loses bit 0
        emit(enc_i(32'd1, 5'd9, 3'b000, 5'd9, OP_IMM));
        dump_reg(5'd8);
        dump_reg(5'd9);
        dump_reg(5'd11);
        dump_reg(5'd12);
        load_const(5'd13, 32'hF1E2_83C4);
        for (int off = 0; off < 4; off++) begin
            emit(enc_s(MEM_BASE + word_t'(off), 5'd13, 5'd0, MEM_B));
            emit(enc_i(32'h35, 5'd13, 3'b000, 5'd13, OP_IMM));
        end
        for (int off = 0; off < 4; off += 2) begin
            emit(enc_s(MEM_BASE + 32'd8 + word_t'(off), 5'd13, 5'd0, MEM_H));
            emit(enc_i(32'h35, 5'd13, 3'b000, 5'd13, OP_IMM));
        end
        emit(enc_s(MEM_BASE + 32'd12, 5'd13, 5'd0, MEM_W));
        for (int off = 0; off < 4; off++) begin
            emit(enc_i(MEM_BASE + word_t'(off), 5'd0, MEM_B, 5'd14, OP_LOAD));
            emit(enc_i(MEM_BASE + word_t'(off), 5'd0, MEM_BU, 5'd15, OP_LOAD));
            dump_reg(5'd14);
            dump_reg(5'd15);
        end
        for (int off = 0; off < 4; off += 2) begin
            emit(enc_i(MEM_BASE + 32'd8 + word_t'(off), 5'd0, MEM_H, 5'd14, OP_LOAD));
            emit(enc_i(MEM_BASE + 32'd8 + word_t'(off), 5'd0, MEM_HU, 5'd15, OP_LOAD));
            dump_reg(5'd14);
            dump_reg(5'd15);
        end
        emit(enc_i(MEM_BASE + 32'd12, 5'd0, MEM_W, 5'd14, OP_LOAD));
        dump_reg(5'd14);
    endtask

    // model steps once per retired instruction
    always @(posedge clk) begin
        if (reset) begin
            if (dmem_we !== 1'b0) begin
                other_errors++;
                $display("data write enable was high while reset was asserted");
            end
        end else begin
            check_word("imem_addr", imem_addr, m_pc);
            ref_step(imem[m_pc[11:2]], m_pc, m_regs, m_dmem, st_en, st_addr, st_data, st_strb);
            check_store(dmem_we, dmem_addr, dmem_wdata, dmem_wstrb,
                        st_en, st_addr, st_data, st_strb);
        end
    end

    initial begin
        wait (prog_ready);
        #((prog.size() + 50) * 100);
        $display("timeout: the program did not reach its end address");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        seed         = 32'd77;
        prog_ready   = 1'b0;
        dump_slot    = 0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        m_pc         = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < REF_DMEM_WORDS; i++) begin
            imem[i]   = NOP_INST;
            dmem[i]   = fill_word(i);
            m_dmem[i] = fill_word(i);
        end
        build_program();
        foreach (prog[i]) begin
            imem[RESET_PC[11:2] + i] = prog[i];
        end
        end_pc     = RESET_PC + word_t'(4 * prog.size());
        prog_ready = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (imem_addr !== end_pc) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
